// File: all.f
soc_bus_pkg.sv
bus_controller.sv
master_mux.sv
scratch_ram.sv
vector_rom.sv
ssram_port.sv
readdata_mux.sv
soc_bus.sv
tb_clock.sv
ssram_model.sv
tb_soc_bus.sv

// File: bus_controller.sv
module bus_controller (
  input logic clock,
  input logic reset,
  input logic map,
  input soc_bus_pkg::bus_addr_t cpu_address,
  input logic cpu_read,
  input logic cpu_write,
  input soc_bus_pkg::bus_addr_t vga_address,
  input logic vga_read,
  output logic cpu_wait,
  output logic vga_wait,
  output logic grant,
  output soc_bus_pkg::chip_select_t chip_select,
  output logic bus_read,
  output logic bus_write,
  output logic ssram_start
);
  import soc_bus_pkg::*;

  logic [1:0] state;
  logic grant_q;
  logic cpu_req;
  logic vga_req;
  logic pick_vga;
  bus_addr_t win_address;
  chip_select_t win_select;

  assign cpu_req = cpu_read | cpu_write;
  assign vga_req = vga_read;

  // vga has priority
  assign pick_vga = vga_req;
  assign win_address = pick_vga ? vga_address : cpu_address;

  // while idle the mux follows the arbiter so the address lands with the grant
  assign grant = (state == st_idle) ? pick_vga : grant_q;

  always_comb begin
    case (win_address.region_view.region)
      region_alias: win_select = map ? cs_vectors : cs_none;
      region_vectors: win_select = cs_vectors;
      region_scratch: win_select = cs_scratch;
      region_ssram: win_select = cs_ssram;
      default: win_select = cs_none;
    endcase
  end

  // wait drops only in the completion cycle of the owner
  assign cpu_wait = cpu_req & ~((state == st_done) & ~grant_q);
  assign vga_wait = vga_req & ~((state == st_done) & grant_q);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      grant_q <= 1'b0;
      chip_select <= cs_none;
      bus_read <= 1'b0;
      bus_write <= 1'b0;
      ssram_start <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (cpu_req | vga_req) begin
            grant_q <= pick_vga;
            chip_select <= win_select;
            bus_read <= pick_vga | cpu_read;
            bus_write <= ~pick_vga & cpu_write;
            ssram_start <= (win_select == cs_ssram);
            state <= st_access;
          end
        end
        st_access: begin
          ssram_start <= 1'b0;
          if (chip_select == cs_ssram) begin
            state <= st_ssram_wait;
          end else begin
            bus_read <= 1'b0;
            bus_write <= 1'b0;
            state <= st_done;
          end
        end
        st_ssram_wait: begin
          // read data is captured at the end of this cycle
          bus_read <= 1'b0;
          bus_write <= 1'b0;
          state <= st_done;
        end
        default: begin
          chip_select <= cs_none;
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

// File: master_mux.sv
module master_mux (
  input logic clock,
  input logic reset,
  input logic grant,
  input soc_bus_pkg::bus_addr_t cpu_address,
  input soc_bus_pkg::bus_addr_t vga_address,
  input soc_bus_pkg::bus_word_t cpu_writedata,
  input soc_bus_pkg::bus_be_t cpu_be,
  output soc_bus_pkg::bus_addr_t bus_address,
  output soc_bus_pkg::bus_word_t bus_writedata,
  output soc_bus_pkg::bus_be_t bus_be
);

  // grant high selects vga
  always_ff @(posedge clock) begin
    if (reset) begin
      bus_address <= '0;
      bus_writedata <= '0;
      bus_be <= '0;
    end else if (grant) begin
      bus_address <= vga_address;
      // vga only reads whole words
      bus_writedata <= '0;
      bus_be <= '1;
    end else begin
      bus_address <= cpu_address;
      bus_writedata <= cpu_writedata;
      bus_be <= cpu_be;
    end
  end

endmodule

// File: readdata_mux.sv
module readdata_mux (
  input soc_bus_pkg::chip_select_t chip_select,
  input soc_bus_pkg::bus_word_t vectors_data,
  input soc_bus_pkg::bus_word_t scratch_data,
  input soc_bus_pkg::bus_word_t ssram_data,
  output soc_bus_pkg::bus_word_t cpu_readdata,
  output soc_bus_pkg::vga_pixel_t vga_readdata
);
  import soc_bus_pkg::*;

  always_comb begin
    case (chip_select)
      cs_vectors: cpu_readdata = vectors_data;
      cs_scratch: cpu_readdata = scratch_data;
      cs_ssram: cpu_readdata = ssram_data;
      // unmapped reads return zero
      default: cpu_readdata = '0;
    endcase
  end

  // pixel is the low three bytes
  assign vga_readdata = cpu_readdata[23:0];

endmodule

// File: scratch_ram.sv
module scratch_ram (
  input logic clock,
  input soc_bus_pkg::bus_addr_t bus_address,
  input soc_bus_pkg::bus_word_t bus_writedata,
  input soc_bus_pkg::bus_be_t bus_be,
  input logic write_enable,
  input logic read_enable,
  output soc_bus_pkg::bus_word_t readdata
);
  import soc_bus_pkg::*;

  bus_word_t mem [scratch_words];
  logic [$clog2(scratch_words)-1:0] index;

  // word index above the byte field
  assign index = bus_address.region_view.offset[$clog2(scratch_words)+1:2];

  always_ff @(posedge clock) begin
    if (write_enable) begin
      for (int i = 0; i < 4; i++) begin
        if (bus_be[i]) begin
          mem[index][8*i +: 8] <= bus_writedata[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (read_enable) begin
      readdata <= mem[index];
    end
  end

endmodule

// File: soc_bus.sv
module soc_bus (
  input logic clock,
  input logic reset,
  input logic map,
  input soc_bus_pkg::bus_addr_t cpu_address,
  input logic cpu_read,
  input logic cpu_write,
  input soc_bus_pkg::bus_word_t cpu_writedata,
  input soc_bus_pkg::bus_be_t cpu_be,
  output soc_bus_pkg::bus_word_t cpu_readdata,
  output logic cpu_wait,
  input soc_bus_pkg::bus_addr_t vga_address,
  input logic vga_read,
  output soc_bus_pkg::vga_pixel_t vga_readdata,
  output logic vga_wait,
  output logic [soc_bus_pkg::ssram_addr_width-1:0] ssram_addr,
  output soc_bus_pkg::bus_be_t ssram_be_n,
  output logic ssram_we_n,
  output logic ssram_oe_n,
  output logic ssram0_ce_n,
  output logic ssram1_ce_n,
  output logic ssram_adsp_n,
  inout wire soc_bus_pkg::bus_word_t fs_databus
);
  import soc_bus_pkg::*;

  logic grant;
  chip_select_t chip_select;
  logic bus_read;
  logic bus_write;
  logic ssram_start;
  bus_addr_t bus_address;
  bus_word_t bus_writedata;
  bus_be_t bus_be;
  bus_word_t vectors_data;
  bus_word_t scratch_data;
  bus_word_t ssram_data;
  bus_word_t ssram_dout;
  logic ssram_dout_en;
  logic vectors_read;
  logic scratch_read;
  logic scratch_write;
  logic ssram_read;
  logic ssram_write;

  // slave strobes qualified by chip select
  assign vectors_read = (chip_select == cs_vectors) & bus_read;
  assign scratch_read = (chip_select == cs_scratch) & bus_read;
  assign scratch_write = (chip_select == cs_scratch) & bus_write;
  assign ssram_read = (chip_select == cs_ssram) & bus_read;
  assign ssram_write = (chip_select == cs_ssram) & bus_write;

  assign fs_databus = ssram_dout_en ? ssram_dout : 'z;

  bus_controller bc0 (
    .clock(clock), .reset(reset), .map(map),
    .cpu_address(cpu_address), .cpu_read(cpu_read), .cpu_write(cpu_write),
    .vga_address(vga_address), .vga_read(vga_read),
    .cpu_wait(cpu_wait), .vga_wait(vga_wait), .grant(grant),
    .chip_select(chip_select), .bus_read(bus_read), .bus_write(bus_write),
    .ssram_start(ssram_start));

  master_mux mux0 (
    .clock(clock), .reset(reset), .grant(grant),
    .cpu_address(cpu_address), .vga_address(vga_address),
    .cpu_writedata(cpu_writedata), .cpu_be(cpu_be),
    .bus_address(bus_address), .bus_writedata(bus_writedata), .bus_be(bus_be));

  scratch_ram ram0 (
    .clock(clock), .bus_address(bus_address), .bus_writedata(bus_writedata),
    .bus_be(bus_be), .write_enable(scratch_write), .read_enable(scratch_read),
    .readdata(scratch_data));

  vector_rom rom0 (
    .clock(clock), .bus_address(bus_address), .read_enable(vectors_read),
    .readdata(vectors_data));

  ssram_port ssram0 (
    .clock(clock), .reset(reset), .bus_address(bus_address),
    .bus_writedata(bus_writedata), .bus_be(bus_be), .ssram_start(ssram_start),
    .bus_read(ssram_read), .bus_write(ssram_write), .fs_din(fs_databus),
    .readdata(ssram_data), .ssram_addr(ssram_addr), .ssram_be_n(ssram_be_n),
    .ssram_we_n(ssram_we_n), .ssram_oe_n(ssram_oe_n),
    .ssram0_ce_n(ssram0_ce_n), .ssram1_ce_n(ssram1_ce_n),
    .ssram_adsp_n(ssram_adsp_n), .ssram_dout(ssram_dout),
    .ssram_dout_en(ssram_dout_en));

  readdata_mux rdmux0 (
    .chip_select(chip_select), .vectors_data(vectors_data),
    .scratch_data(scratch_data), .ssram_data(ssram_data),
    .cpu_readdata(cpu_readdata), .vga_readdata(vga_readdata));

endmodule

// File: soc_bus_pkg.sv
package soc_bus_pkg;

  typedef logic [31:0] bus_word_t;
  typedef logic [3:0] bus_be_t;
  typedef logic [23:0] vga_pixel_t;
  typedef logic [3:0] chip_select_t;

  // chip select codes
  localparam chip_select_t cs_none = 4'h0;
  localparam chip_select_t cs_vectors = 4'h1;
  localparam chip_select_t cs_scratch = 4'h3;
  localparam chip_select_t cs_ssram = 4'h6;

  // top address nibble
  localparam logic [3:0] region_alias = 4'h0;
  localparam logic [3:0] region_vectors = 4'h1;
  localparam logic [3:0] region_scratch = 4'h3;
  localparam logic [3:0] region_ssram = 4'h6;

  localparam int scratch_words = 4096;
  localparam int vector_words = 32;
  localparam int ssram_addr_width = 27;

  // controller states
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_access = 2'd1;
  localparam logic [1:0] st_ssram_wait = 2'd2;
  localparam logic [1:0] st_done = 2'd3;

  typedef struct packed {
    logic [3:0] region;
    logic [27:0] offset;
  } region_view_t;

  // bit 22 picks the chip
  typedef struct packed {
    logic [3:0] region;
    logic [4:0] unused;
    logic chip;
    logic [19:0] word_index;
    logic [1:0] byte_sel;
  } ssram_view_t;

  typedef union packed {
    region_view_t region_view;
    ssram_view_t ssram_view;
  } bus_addr_t;

endpackage

// File: ssram_model.sv
module ssram_model (
  input logic clock,
  input logic [soc_bus_pkg::ssram_addr_width-1:0] ssram_addr,
  input soc_bus_pkg::bus_be_t ssram_be_n,
  input logic ssram_we_n,
  input logic ssram_oe_n,
  input logic ssram0_ce_n,
  input logic ssram1_ce_n,
  input logic ssram_adsp_n,
  inout wire soc_bus_pkg::bus_word_t fs_databus,
  output logic both_enabled
);
  timeunit 1ns;
  timeprecision 1ps;
  import soc_bus_pkg::*;

  // sparse storage, unwritten words read as zero
  bus_word_t chip0 [int];
  bus_word_t chip1 [int];
  bus_word_t read_word;
  logic driving = 1'b0;

  assign both_enabled = ~ssram0_ce_n & ~ssram1_ce_n;

  // read word appears one cycle after the address strobe
  assign fs_databus = (driving && !ssram_oe_n) ? read_word : 'z;

  always @(posedge clock) begin : access
    bus_word_t word;
    int key;
    key = int'(ssram_addr);
    driving <= 1'b0;
    if (!ssram_adsp_n && !(ssram0_ce_n && ssram1_ce_n)) begin
      if (!ssram0_ce_n) begin
        word = chip0.exists(key) ? chip0[key] : '0;
      end else begin
        word = chip1.exists(key) ? chip1[key] : '0;
      end
      if (!ssram_we_n) begin
        for (int i = 0; i < 4; i++) begin
          if (!ssram_be_n[i]) begin
            word[8*i +: 8] = fs_databus[8*i +: 8];
          end
        end
        if (!ssram0_ce_n) begin
          chip0[key] = word;
        end else begin
          chip1[key] = word;
        end
      end else begin
        read_word <= word;
        driving <= 1'b1;
      end
    end
  end

endmodule

// File: ssram_port.sv
module ssram_port (
  input logic clock,
  input logic reset,
  input soc_bus_pkg::bus_addr_t bus_address,
  input soc_bus_pkg::bus_word_t bus_writedata,
  input soc_bus_pkg::bus_be_t bus_be,
  input logic ssram_start,
  input logic bus_read,
  input logic bus_write,
  input soc_bus_pkg::bus_word_t fs_din,
  output soc_bus_pkg::bus_word_t readdata,
  output logic [soc_bus_pkg::ssram_addr_width-1:0] ssram_addr,
  output soc_bus_pkg::bus_be_t ssram_be_n,
  output logic ssram_we_n,
  output logic ssram_oe_n,
  output logic ssram0_ce_n,
  output logic ssram1_ce_n,
  output logic ssram_adsp_n,
  output soc_bus_pkg::bus_word_t ssram_dout,
  output logic ssram_dout_en
);
  import soc_bus_pkg::*;

  logic active;
  logic start_d1;

  assign active = bus_read | bus_write;

  // single word accesses, no burst advance
  assign ssram_addr = ssram_addr_width'(bus_address.ssram_view.word_index);
  assign ssram_adsp_n = ~ssram_start;
  assign ssram0_ce_n = ~(active & ~bus_address.ssram_view.chip);
  assign ssram1_ce_n = ~(active & bus_address.ssram_view.chip);

  // write is taken with the address
  assign ssram_we_n = ~(bus_write & ssram_start);
  assign ssram_be_n = bus_write ? ~bus_be : 4'b1111;
  assign ssram_oe_n = ~bus_read;
  assign ssram_dout = bus_writedata;
  assign ssram_dout_en = bus_write;

  always_ff @(posedge clock) begin
    if (reset) begin
      start_d1 <= 1'b0;
    end else begin
      start_d1 <= ssram_start;
    end
  end

  // chip drives the word one cycle after the address
  always_ff @(posedge clock) begin
    if (start_d1 && bus_read) begin
      readdata <= fs_din;
    end
  end

endmodule

// File: tb_clock.sv
module tb_clock (
  output logic clock
);
  timeunit 1ns;
  timeprecision 1ps;

  // 10 ns period
  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

endmodule

// File: tb_soc_bus.sv
module tb_soc_bus;
  timeunit 1ns;
  timeprecision 1ps;
  import soc_bus_pkg::*;

  logic clock;
  logic reset;
  logic map;
  bus_addr_t cpu_address;
  logic cpu_read;
  logic cpu_write;
  bus_word_t cpu_writedata;
  bus_be_t cpu_be;
  bus_word_t cpu_readdata;
  logic cpu_wait;
  bus_addr_t vga_address;
  logic vga_read;
  vga_pixel_t vga_readdata;
  logic vga_wait;
  logic [ssram_addr_width-1:0] ssram_addr;
  bus_be_t ssram_be_n;
  logic ssram_we_n;
  logic ssram_oe_n;
  logic ssram0_ce_n;
  logic ssram1_ce_n;
  logic ssram_adsp_n;
  wire bus_word_t fs_databus;
  logic both_enabled;

  integer seed = 32'h5532;
  string test_name = "reset";
  int value_errors = 0;
  int protocol_errors = 0;
  int cycle_count = 0;
  // scratch 48, vectors 48, ssram 16, pairs 8, unmapped 10, random 300
  int cycle_limit = 20 * (48 + 48 + 16 + 8 + 10 + 300) + 200;
  int cpu_cycles = 0;
  int vga_cycles = 0;
  int cpu_done_cycle = 0;
  int vga_done_cycle = 0;
  bus_word_t rom_image [vector_words];
  bus_word_t scratch_shadow [scratch_words];
  bus_word_t ssram_shadow [int];
  bus_addr_t vga_list [150];

  tb_clock clock_gen (.clock(clock));

  soc_bus soc_bus_i (.*);

  ssram_model chips (.*);

  function automatic bus_word_t merge_bytes(input bus_word_t old_word,
      input bus_word_t new_word, input bus_be_t be);
    bus_word_t result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        result[8*i +: 8] = new_word[8*i +: 8];
      end
    end
    return result;
  endfunction

  // expected read data under the address map
  function automatic bus_word_t expected_word(input bus_addr_t address);
    int word;
    int key;
    word = address.region_view.offset / 4;
    key = {address.ssram_view.chip, address.ssram_view.word_index};
    case (address.region_view.region)
      region_alias: return map ? rom_image[word % vector_words] : '0;
      region_vectors: return rom_image[word % vector_words];
      region_scratch: return scratch_shadow[word % scratch_words];
      region_ssram: return ssram_shadow.exists(key) ? ssram_shadow[key] : '0;
      default: return '0;
    endcase
  endfunction

  function automatic void shadow_write(input bus_addr_t address, input bus_word_t data,
      input bus_be_t be);
    int word;
    int key;
    word = address.region_view.offset / 4 % scratch_words;
    key = {address.ssram_view.chip, address.ssram_view.word_index};
    if (address.region_view.region == region_scratch) begin
      scratch_shadow[word] = merge_bytes(scratch_shadow[word], data, be);
    end else if (address.region_view.region == region_ssram) begin
      ssram_shadow[key] = merge_bytes(expected_word(address), data, be);
    end
  endfunction

  // small windows so reads hit written words
  function automatic bus_addr_t random_address();
    int index;
    index = $unsigned($random(seed)) % 16;
    case ($unsigned($random(seed)) % 6)
      0: return 32'h1000_0000 + index * 8;
      1: return 32'h3000_0000 + index * 4;
      2: return 32'h6000_0000 + index * 4;
      3: return 32'h6040_0000 + index * 4;
      4: return 32'h0000_0000 + index * 4;
      default: return 32'h9000_0000 + index * 4;
    endcase
  endfunction

  task automatic check_word(input string name, input bus_word_t expected,
      input bus_word_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_pixel(input string name, input vga_pixel_t expected,
      input vga_pixel_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic cpu_access(input bus_addr_t address, input logic write,
      input bus_word_t data, input bus_be_t be);
    @(posedge clock);
    cpu_address <= address;
    cpu_read <= !write;
    cpu_write <= write;
    cpu_writedata <= data;
    cpu_be <= be;
    do begin
      @(posedge clock);
    end while (cpu_wait !== 1'b0);
    cpu_read <= 1'b0;
    cpu_write <= 1'b0;
  endtask

  task automatic vga_access(input bus_addr_t address);
    @(posedge clock);
    vga_address <= address;
    vga_read <= 1'b1;
    do begin
      @(posedge clock);
    end while (vga_wait !== 1'b0);
    vga_read <= 1'b0;
  endtask

  // an edge with no completion, so the name never changes under a check
  task automatic start_test(input string name);
    @(posedge clock);
    test_name = name;
  endtask

  always @(posedge clock) begin : compare
    bus_word_t reference;
    if (!reset) begin
      if (both_enabled) begin
        protocol_errors++;
        $display("ssram model saw both chip enables low at cycle %0d", cycle_count);
      end
      if ((cpu_read || cpu_write) && !cpu_wait) begin
        if (cpu_cycles < ((cpu_address.region_view.region == region_ssram) ? 3 : 2)) begin
          protocol_errors++;
          $display("cpu got data for %h while its wait should still be high", cpu_address);
        end
        if (cpu_read) begin
          check_word(test_name, expected_word(cpu_address), cpu_readdata);
        end else begin
          shadow_write(cpu_address, cpu_writedata, cpu_be);
        end
        cpu_cycles = 0;
        cpu_done_cycle = cycle_count;
      end else if (cpu_read || cpu_write) begin
        cpu_cycles++;
      end
      if (vga_read && !vga_wait) begin
        if (vga_cycles < ((vga_address.region_view.region == region_ssram) ? 3 : 2)) begin
          protocol_errors++;
          $display("vga got data for %h while its wait should still be high", vga_address);
        end
        reference = expected_word(vga_address);
        check_pixel(test_name, reference[23:0], vga_readdata);
        vga_cycles = 0;
        vga_done_cycle = cycle_count;
      end else if (vga_read) begin
        vga_cycles++;
      end
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("run did not finish within %0d cycles", cycle_limit);
      $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    reset = 1'b1;
    map = 1'b1;
    cpu_address = '0;
    cpu_read = 1'b0;
    cpu_write = 1'b0;
    cpu_writedata = '0;
    cpu_be = '0;
    vga_address = '0;
    vga_read = 1'b0;
    $readmemh("vectors.hex", rom_image);
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    if (!(ssram0_ce_n && ssram1_ce_n && ssram_adsp_n && ssram_we_n && ssram_oe_n)) begin
      protocol_errors++;
      $display("ssram enables are not inactive after reset");
    end

    start_test("scratch byte enables");
    for (int i = 0; i < 16; i++) begin
      cpu_access(32'h3000_0000 + i * 4, 1'b1, $random(seed), 4'hf);
    end
    for (int i = 0; i < 16; i++) begin
      cpu_access(32'h3000_0000 + i * 4, 1'b1, $random(seed), bus_be_t'($random(seed)));
    end
    for (int i = 0; i < 16; i++) begin
      cpu_access(32'h3000_0000 + i * 4, 1'b0, '0, 4'hf);
    end

    start_test("vector rom");
    for (int i = 0; i < 32; i++) begin
      cpu_access(32'h1000_0000 + i * 4, 1'b0, '0, 4'hf);
    end
    start_test("region 0 alias");
    for (int i = 0; i < 8; i++) begin
      vga_access(i * 4);
    end
    start_test("region 0 unmapped");
    map <= 1'b0;
    for (int i = 0; i < 8; i++) begin
      cpu_access(i * 4, 1'b0, '0, 4'hf);
    end

    start_test("ssram both chips");
    map <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      cpu_access(32'h6000_0000 + (i % 2) * 32'h0040_0000 + i * 32'h1004, 1'b1,
        $random(seed), 4'hf);
    end
    for (int i = 0; i < 8; i++) begin
      cpu_access(32'h6000_0000 + (i % 2) * 32'h0040_0000 + i * 32'h1004, 1'b0, '0, 4'hf);
    end

    start_test("simultaneous requests");
    for (int i = 0; i < 4; i++) begin
      fork
        cpu_access(32'h3000_0000 + i * 4, 1'b0, '0, 4'hf);
        vga_access(32'h6000_0000 + (i % 2) * 32'h0040_0000 + i * 32'h1004);
      join
      @(posedge clock);
      if (vga_done_cycle >= cpu_done_cycle) begin
        protocol_errors++;
        $display("vga wait did not fall before cpu wait in pair %0d", i);
      end
    end

    start_test("unmapped regions");
    // regions 2, 5, 8 and b at offset zero
    for (int i = 0; i < 4; i++) begin
      cpu_access(32'h2000_0000 + i * 32'h3000_0000, 1'b1, 32'ha5a5_a5a5, 4'hf);
    end
    for (int i = 0; i < 4; i++) begin
      cpu_access(32'h2000_0000 + i * 32'h3000_0000, 1'b0, '0, 4'hf);
    end
    cpu_access(32'h3000_0000, 1'b0, '0, 4'hf);
    cpu_access(32'h6000_0000, 1'b0, '0, 4'hf);

    start_test("random mixed");
    for (int i = 0; i < 150; i++) begin
      vga_list[i] = random_address();
    end
    fork
      for (int i = 0; i < 150; i++) begin
        cpu_access(random_address(), 1'($random(seed)), $random(seed),
          bus_be_t'($random(seed)));
      end
      for (int j = 0; j < 150; j++) begin
        vga_access(vga_list[j]);
      end
    join

    repeat (2) @(posedge clock);
    $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: vector_rom.sv
module vector_rom (
  input logic clock,
  input soc_bus_pkg::bus_addr_t bus_address,
  input logic read_enable,
  output soc_bus_pkg::bus_word_t readdata
);
  import soc_bus_pkg::*;

  bus_word_t rom [vector_words];
  logic [$clog2(vector_words)-1:0] index;

  initial begin
    $readmemh("vectors.hex", rom);
  end

  assign index = bus_address.region_view.offset[$clog2(vector_words)+1:2];

  always_ff @(posedge clock) begin
    if (read_enable) begin
      readdata <= rom[index];
    end
  end

endmodule

// File: vectors.hex
// vector table, one 32-bit word per line starting at word 0
30004000
0800042C
08000458
08000484
080004B0
080004DC
08000508
08000534
08000560
0800058C
080005B8
080005E4
08000610
0800063C
08000668
08000694
080006C0
080006EC
08000718
08000744
08000770
0800079C
080007C8
080007F4
08000820
0800084C
08000878
080008A4
080008D0
080008FC
08000928
08000954
